/* verilog/pixels_pkg.sv */
package pixels_pkg;

  // Pixel word and window geometry
  localparam int WORD_WIDTH = 8;
  localparam int ROWS = 4;
  localparam int EDGE_WORDS = 1;
  localparam int COL_WORDS = ROWS + EDGE_WORDS;

  // Top halo word in front of the column words
  localparam int SHIFT_WORDS = COL_WORDS + EDGE_WORDS;

  // Frame size limits
  localparam int XW_MAX = 16;
  localparam int CI_MAX = 4;
  localparam int BLOCKS_MAX = 4;

  // One edge word per column of a row block
  localparam int RAM_DEPTH = XW_MAX * CI_MAX;

  localparam int USER_WIDTH = 9;

  // Header bit positions, blocks-1 sits in the top bits
  localparam int HDR_KH2_LSB = 0;
  localparam int HDR_W_LSB = 1;
  localparam int HDR_CI_LSB = 5;
  localparam int HDR_BLK_LSB = 7;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // Counter fields hold count minus one
  typedef logic [0:0] kh2_t;
  typedef logic [$clog2(CI_MAX)-1:0] ci_t;
  typedef logic [$clog2(XW_MAX)-1:0] xw_t;
  typedef logic [$clog2(BLOCKS_MAX)-1:0] blk_t;

  typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;

  // Header handling in the gatherer
  typedef enum logic [1:0] {
    SET,
    PASS,
    BLOCK
  } pix_state_t;

endpackage

/* verilog/pixels_if.sv */
`timescale 1ns/1ps

// Column beats from gatherer to shifter
interface col_if;

  logic valid;
  logic ready;
  logic last;
  pixels_pkg::word_t [pixels_pkg::COL_WORDS-1:0] data;

  modport producer (output valid, output data, output last, input ready);
  modport consumer (input valid, input data, input last, output ready);

endinterface

// Frame configuration, taken from the header
interface cfg_if;

  logic load;
  logic done;
  pixels_pkg::kh2_t kh2;
  pixels_pkg::ci_t ci;
  pixels_pkg::xw_t w;
  pixels_pkg::blk_t blocks;

  modport producer (
    output load, output kh2, output ci, output w, output blocks,
    input done
  );
  modport consumer (
    input load, input kh2, input ci, input w, input blocks,
    output done
  );

endinterface

/* verilog/column_gatherer.sv */
`timescale 1ns/1ps

module column_gatherer (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic                               i_s_valid,
  output logic                               o_s_ready,
  input  logic                               i_s_last,
  input  pixels_pkg::word_t                  i_s_data,
  input  logic [pixels_pkg::USER_WIDTH-1:0]  i_s_user,
  col_if.producer                            col,
  cfg_if.producer                            cfg
);

  pixels_pkg::pix_state_t state;
  logic [$clog2(pixels_pkg::COL_WORDS)-1:0] word_cnt;
  logic take_hdr;
  logic s_beat;
  logic col_end;

  // Header is sampled without ready
  assign take_hdr = (state == pixels_pkg::SET) && i_s_valid;

  // Input stalls while a column beat waits
  assign o_s_ready = (state == pixels_pkg::PASS) && !col.valid;
  assign s_beat = i_s_valid && o_s_ready;

  // Bottom halo word only with a 3-row kernel
  assign col_end = int'(word_cnt) ==
                   (cfg.kh2 ? pixels_pkg::COL_WORDS - 1 : pixels_pkg::ROWS - 1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= pixels_pkg::SET;
    end else begin
      case (state)
        pixels_pkg::SET: if (i_s_valid) state <= pixels_pkg::PASS;
        pixels_pkg::PASS: if (s_beat && i_s_last) state <= pixels_pkg::BLOCK;
        pixels_pkg::BLOCK: if (cfg.done) state <= pixels_pkg::SET;
        default: state <= pixels_pkg::SET;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg.load <= 1'b0;
      cfg.kh2 <= '0;
      cfg.ci <= '0;
      cfg.w <= '0;
      cfg.blocks <= '0;
    end else begin
      cfg.load <= take_hdr;
      if (take_hdr) begin
        cfg.kh2 <= i_s_user[pixels_pkg::HDR_KH2_LSB];
        cfg.ci <= i_s_user[pixels_pkg::HDR_CI_LSB +: $bits(pixels_pkg::ci_t)];
        cfg.w <= i_s_user[pixels_pkg::HDR_W_LSB +: $bits(pixels_pkg::xw_t)];
        cfg.blocks <= i_s_user[pixels_pkg::HDR_BLK_LSB +: $bits(pixels_pkg::blk_t)];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      word_cnt <= '0;
      col.valid <= 1'b0;
      col.last <= 1'b0;
    end else begin
      if (col.valid && col.ready) begin
        col.valid <= 1'b0;
      end
      if (s_beat) begin
        if (col_end) begin
          word_cnt <= '0;
          col.valid <= 1'b1;
          col.last <= i_s_last;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Word n of the column lands in slot n
  always_ff @(posedge aclk) begin
    if (s_beat) begin
      col.data[word_cnt] <= i_s_data;
    end
  end

  assert property (@(posedge aclk) disable iff (!aresetn)
    (state == pixels_pkg::SET) |-> !o_s_ready)
    else $error("o_s_ready high while reading a header");

endmodule

/* verilog/edge_line_ram.sv */
`timescale 1ns/1ps

module edge_line_ram (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_ren,
  input  logic                  i_wen,
  input  pixels_pkg::ram_addr_t i_addr,
  input  pixels_pkg::word_t     i_din,
  output pixels_pkg::word_t     o_dout
);

  pixels_pkg::word_t mem [pixels_pkg::RAM_DEPTH];
  pixels_pkg::word_t rd_q;
  pixels_pkg::word_t hold_q;
  logic rd_vld;

  // Read-first port, a write also refreshes the output register
  always_ff @(posedge aclk) begin
    if (i_ren || i_wen) begin
      rd_q <= mem[i_addr];
      if (i_wen) begin
        mem[i_addr] <= i_din;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= i_ren;
    end
  end

  // Keeps the last read word across writes and idle cycles
  always_ff @(posedge aclk) begin
    if (rd_vld) begin
      hold_q <= rd_q;
    end
  end

  assign o_dout = rd_vld ? rd_q : hold_q;

  assert property (@(posedge aclk) disable iff (!aresetn)
    !(i_ren && i_wen))
    else $error("edge RAM read and write in the same cycle");

endmodule

/* verilog/window_shifter.sv */
`timescale 1ns/1ps

module window_shifter (
  input  logic                                       aclk,
  input  logic                                       aresetn,
  col_if.consumer                                    col,
  cfg_if.consumer                                    cfg,
  output logic                                       o_ram_ren,
  output logic                                       o_ram_wen,
  output pixels_pkg::ram_addr_t                      o_ram_addr,
  output pixels_pkg::word_t                          o_ram_din,
  input  pixels_pkg::word_t                          i_ram_dout,
  input  logic                                       i_m_ready,
  output logic                                       o_m_valid,
  output logic                                       o_m_last,
  output pixels_pkg::word_t [pixels_pkg::ROWS-1:0]   o_m_data
);

  // Column side counters
  pixels_pkg::ci_t ci_cnt;
  pixels_pkg::xw_t w_cnt;
  pixels_pkg::blk_t blk_cnt;
  pixels_pkg::ram_addr_t addr_cnt;
  logic ci_last;
  logic w_last;
  logic blk_first;
  logic blk_last;

  // Handshake between stages
  logic col_fire;
  logic r_free;
  logic load_sh;
  logic out_fire;
  logic wr_set;

  // Pipeline stage matching RAM latency
  logic valid_r;
  logic last_r;
  logic first_r;
  logic lastblk_r;
  pixels_pkg::ram_addr_t addr_r;
  pixels_pkg::word_t [pixels_pkg::COL_WORDS-1:0] data_r;
  pixels_pkg::word_t edge_top;

  // Output stage
  pixels_pkg::word_t [pixels_pkg::SHIFT_WORDS-1:0] shift_q;
  logic [1:0] step;
  logic step_last;
  logic last_sh;

  // Deferred edge word write
  logic wr_pend;
  pixels_pkg::ram_addr_t wr_addr;
  pixels_pkg::word_t wr_data;

  assign ci_last = (ci_cnt == cfg.ci);
  assign w_last = (w_cnt == cfg.w);
  assign blk_first = (blk_cnt == '0);
  assign blk_last = (blk_cnt == cfg.blocks);

  // 2*kh2 + 1 windows per column
  assign step_last = (step == {cfg.kh2, 1'b0});

  assign out_fire = o_m_valid && i_m_ready;
  assign load_sh = i_m_ready && valid_r && (!o_m_valid || step_last);
  assign r_free = !valid_r || load_sh;
  assign wr_set = load_sh && cfg.kh2 && !lastblk_r;

  // Edge write goes first, so a read never meets a stale word
  assign col.ready = i_m_ready && r_free && !wr_set && !wr_pend;
  assign col_fire = col.valid && col.ready;

  assign o_ram_ren = col_fire && cfg.kh2 && !blk_first;
  assign o_ram_wen = wr_pend && i_m_ready;
  assign o_ram_addr = o_ram_wen ? wr_addr : addr_cnt;
  assign o_ram_din = wr_data;

  always_ff @(posedge aclk) begin
    if (!aresetn || cfg.load) begin
      ci_cnt <= '0;
      w_cnt <= '0;
      blk_cnt <= '0;
      addr_cnt <= '0;
    end else if (col_fire) begin
      ci_cnt <= ci_last ? '0 : ci_cnt + 1'b1;
      if (ci_last) begin
        w_cnt <= w_last ? '0 : w_cnt + 1'b1;
        if (w_last) begin
          blk_cnt <= blk_last ? '0 : blk_cnt + 1'b1;
        end
      end
      // One RAM entry per column of a block
      addr_cnt <= (ci_last && w_last) ? '0 : addr_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      valid_r <= 1'b0;
    end else if (col_fire) begin
      valid_r <= 1'b1;
    end else if (load_sh) begin
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (col_fire) begin
      data_r <= col.data;
      last_r <= col.last;
      first_r <= blk_first;
      lastblk_r <= blk_last;
      addr_r <= addr_cnt;
    end
  end

  // Zero halo above the first block
  assign edge_top = (first_r || !cfg.kh2) ? '0 : i_ram_dout;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_m_valid <= 1'b0;
      last_sh <= 1'b0;
      step <= '0;
    end else if (load_sh) begin
      o_m_valid <= 1'b1;
      last_sh <= last_r;
      step <= '0;
    end else if (out_fire) begin
      if (step_last) begin
        o_m_valid <= 1'b0;
      end
      step <= step + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_sh) begin
      shift_q <= {data_r, edge_top};
    end else if (out_fire) begin
      shift_q <= shift_q >> pixels_pkg::WORD_WIDTH;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_pend <= 1'b0;
    end else begin
      if (o_ram_wen) begin
        wr_pend <= 1'b0;
      end
      if (wr_set) begin
        wr_pend <= 1'b1;
      end
    end
  end

  // Row ROWS-1 becomes the next block's top halo
  always_ff @(posedge aclk) begin
    if (wr_set) begin
      wr_addr <= addr_r;
      wr_data <= data_r[pixels_pkg::ROWS-1];
    end
  end

  always_comb begin
    for (int r = 0; r < pixels_pkg::ROWS; r++) begin
      o_m_data[r] = shift_q[r + pixels_pkg::EDGE_WORDS - int'(cfg.kh2)];
    end
  end

  assign o_m_last = o_m_valid && last_sh && step_last;
  assign cfg.done = out_fire && o_m_last;

  assert property (@(posedge aclk) disable iff (!aresetn)
    (o_m_valid && !i_m_ready) |=> o_m_valid && $stable(o_m_data))
    else $error("o_m_data changed while waiting for i_m_ready");

endmodule

/* verilog/axis_pixels.sv */
`timescale 1ns/1ps

module axis_pixels (
  input  logic                                       aclk,
  input  logic                                       aresetn,
  output logic                                       o_s_ready,
  input  logic                                       i_s_valid,
  input  logic                                       i_s_last,
  input  pixels_pkg::word_t                          i_s_data,
  input  logic [pixels_pkg::USER_WIDTH-1:0]          i_s_user,
  input  logic                                       i_m_ready,
  output logic                                       o_m_valid,
  output logic                                       o_m_last,
  output pixels_pkg::word_t [pixels_pkg::ROWS-1:0]   o_m_data
);

  logic ram_ren;
  logic ram_wen;
  pixels_pkg::ram_addr_t ram_addr;
  pixels_pkg::word_t ram_din;
  pixels_pkg::word_t ram_dout;

  col_if col_bus ();
  cfg_if cfg_bus ();

  column_gatherer gather_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_user  (i_s_user),
    .col       (col_bus.producer),
    .cfg       (cfg_bus.producer)
  );

  edge_line_ram ram_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_ren   (ram_ren),
    .i_wen   (ram_wen),
    .i_addr  (ram_addr),
    .i_din   (ram_din),
    .o_dout  (ram_dout)
  );

  window_shifter shift_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .col        (col_bus.consumer),
    .cfg        (cfg_bus.consumer),
    .o_ram_ren  (ram_ren),
    .o_ram_wen  (ram_wen),
    .o_ram_addr (ram_addr),
    .o_ram_din  (ram_din),
    .i_ram_dout (ram_dout),
    .i_m_ready  (i_m_ready),
    .o_m_valid  (o_m_valid),
    .o_m_last   (o_m_last),
    .o_m_data   (o_m_data)
  );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
  output logic aclk,
  output logic aresetn
);

  localparam int PERIOD_NS = 8;
  localparam int RESET_CYCLES = 8;

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Release just after an edge, like the other inputs
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1 aresetn = 1'b1;
  end

endmodule

/* test/axis_pixels_tb.sv */
`timescale 1ns/1ps

module axis_pixels_tb;

  localparam int DRIVE_DELAY = 1;
  localparam int WAIT_LIMIT = 4000;
  localparam int FRAMES = 8;
  localparam logic [31:0] SEED = 32'ha879;

  typedef pixels_pkg::word_t [pixels_pkg::ROWS-1:0] window_t;

  logic aclk;
  logic aresetn;
  logic s_ready;
  logic s_valid;
  logic s_last;
  pixels_pkg::word_t s_data;
  logic [pixels_pkg::USER_WIDTH-1:0] s_user;
  logic m_ready;
  logic m_valid;
  logic m_last;
  window_t m_data;

  logic [31:0] rand_state;
  int errors;
  int timeouts;
  int win_count;
  int total_windows;
  logic last_seen;
  pixels_pkg::word_t frame_words[$];
  window_t exp_data_q[$];
  logic exp_last_q[$];
  window_t exp_win;
  logic exp_last;
  logic exp_avail;

  clock_gen clk_i (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  axis_pixels axis_pixels_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .o_s_ready (s_ready),
    .i_s_valid (s_valid),
    .i_s_last  (s_last),
    .i_s_data  (s_data),
    .i_s_user  (s_user),
    .i_m_ready (m_ready),
    .o_m_valid (m_valid),
    .o_m_last  (m_last),
    .o_m_data  (m_data)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic log_error(input string msg);
    $display("Fail %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic void refresh_front();
    exp_avail = (exp_data_q.size() != 0);
    if (exp_avail) begin
      exp_win = exp_data_q[0];
      exp_last = exp_last_q[0];
    end
  endfunction

  // Random words for one frame and the windows they should produce
  task automatic build_frame(input logic [pixels_pkg::USER_WIDTH-1:0] hdr, output int count);
    int kh2;
    int w;
    int ci;
    int blocks;
    int j;
    pixels_pkg::word_t col_words [pixels_pkg::COL_WORDS];
    pixels_pkg::word_t ext [pixels_pkg::SHIFT_WORDS];
    pixels_pkg::word_t edge_row [pixels_pkg::RAM_DEPTH];
    window_t win;
    kh2 = int'(hdr[pixels_pkg::HDR_KH2_LSB]);
    w = int'(hdr[pixels_pkg::HDR_W_LSB +: $bits(pixels_pkg::xw_t)]) + 1;
    ci = int'(hdr[pixels_pkg::HDR_CI_LSB +: $bits(pixels_pkg::ci_t)]) + 1;
    blocks = int'(hdr[pixels_pkg::HDR_BLK_LSB +: $bits(pixels_pkg::blk_t)]) + 1;
    count = 0;
    frame_words.delete();
    for (int b = 0; b < blocks; b++) begin
      for (int x = 0; x < w; x++) begin
        for (int c = 0; c < ci; c++) begin
          j = x * ci + c;
          for (int i = 0; i < pixels_pkg::ROWS + kh2; i++) begin
            rand_state = lcg_step(rand_state);
            col_words[i] = rand_state[31:24];
            frame_words.push_back(col_words[i]);
            ext[i + kh2] = col_words[i];
          end
          // Same column one block up, zero above block 0
          if (kh2 == 1) begin
            ext[0] = (b == 0) ? '0 : edge_row[j];
          end
          for (int k = 0; k <= 2 * kh2; k++) begin
            for (int r = 0; r < pixels_pkg::ROWS; r++) begin
              win[r] = ext[r + k];
            end
            exp_data_q.push_back(win);
            exp_last_q.push_back(b == blocks - 1 && x == w - 1 && c == ci - 1 && k == 2 * kh2);
            count++;
          end
          edge_row[j] = col_words[pixels_pkg::ROWS - 1];
        end
      end
    end
    refresh_front();
  endtask

  task automatic drive_frame(input logic [pixels_pkg::USER_WIDTH-1:0] hdr);
    int cycles;
    logic taken;
    for (int i = 0; i < frame_words.size() && timeouts == 0; i++) begin
      rand_state = lcg_step(rand_state);
      if (rand_state[31:30] == 2'b00) begin
        s_valid = 1'b0;
        repeat (int'(rand_state[29:28]) + 1) @(posedge aclk);
        #(DRIVE_DELAY);
      end
      s_valid = 1'b1;
      s_data = frame_words[i];
      s_last = (i == frame_words.size() - 1);
      s_user = hdr;
      cycles = 0;
      taken = 1'b0;
      while (!taken && cycles < WAIT_LIMIT) begin
        @(posedge aclk);
        taken = s_ready;
        cycles++;
      end
      #(DRIVE_DELAY);
      if (!taken) begin
        timeouts++;
        $display("Timeout: input word %0d of the frame was never accepted", i);
      end
    end
    s_valid = 1'b0;
    s_last = 1'b0;
  endtask

  task automatic wait_windows();
    int cycles;
    cycles = 0;
    while (!last_seen && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      #(DRIVE_DELAY);
      cycles++;
    end
    if (!last_seen) begin
      timeouts++;
      $display("Timeout: the final window of the frame never came out, %0d still expected",
               exp_data_q.size());
    end
  endtask

  // Every output transfer counts, expected or not
  always @(posedge aclk) begin
    if (aresetn && m_valid && m_ready) begin
      win_count++;
      total_windows++;
      if (m_last) begin
        last_seen = 1'b1;
      end
      if (exp_avail) begin
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        refresh_front();
      end
    end
  end

  // Output back-pressure, about one cycle in four
  initial begin
    logic [31:0] ready_state;
    ready_state = SEED;
    m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #(DRIVE_DELAY);
      ready_state = lcg_step(ready_state);
      m_ready = (ready_state[31:30] != 2'b00);
    end
  end

  assert property (@(posedge aclk) !aresetn |=> !s_ready && !m_valid)
    else log_error("o_s_ready or o_m_valid high during or right after reset");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && m_ready) |-> exp_avail)
    else log_error("window transferred with none expected");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && m_ready && exp_avail) |-> m_data == exp_win)
    else log_error($sformatf("window %h, expected %h", $sampled(m_data), $sampled(exp_win)));

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && m_ready && exp_avail) |-> m_last == exp_last)
    else log_error("o_m_last does not match the final window");

  assert property (@(posedge aclk) disable iff (!aresetn) m_last |-> m_valid)
    else log_error("o_m_last high without o_m_valid");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && !m_ready) |=> m_valid && $stable(m_data) && $stable(m_last))
    else log_error("output changed while i_m_ready was low");

  initial begin
    logic [pixels_pkg::USER_WIDTH-1:0] hdr;
    int cycles;
    int expected;
    int frames_done;
    s_valid = 1'b0;
    s_last = 1'b0;
    s_data = '0;
    s_user = '0;
    rand_state = SEED;
    errors = 0;
    timeouts = 0;
    total_windows = 0;
    frames_done = 0;
    last_seen = 1'b0;
    refresh_front();
    cycles = 0;
    while (aresetn !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    #(DRIVE_DELAY);
    if (aresetn !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    for (int f = 0; f < FRAMES && timeouts == 0; f++) begin
      rand_state = lcg_step(rand_state);
      hdr = rand_state[31:23];
      // Alternate kernel heights, frame 1 spans four blocks
      hdr[pixels_pkg::HDR_KH2_LSB] = f[0];
      if (f == 1) begin
        hdr[pixels_pkg::HDR_BLK_LSB +: $bits(pixels_pkg::blk_t)] = '1;
      end
      build_frame(hdr, expected);
      win_count = 0;
      last_seen = 1'b0;
      drive_frame(hdr);
      wait_windows();
      assert (win_count == expected)
        else log_error($sformatf("frame %0d gave %0d windows, expected %0d", f, win_count,
                                 expected));
      frames_done++;
    end
    $display("Frames %0d, windows %0d, errors %0d, timeouts %0d", frames_done, total_windows,
             errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/pixels_pkg.sv
verilog/pixels_if.sv
verilog/column_gatherer.sv
verilog/edge_line_ram.sv
verilog/window_shifter.sv
verilog/axis_pixels.sv
test/clock_gen.sv
test/axis_pixels_tb.sv
